// File: hdl/pf_pkg.sv
package pf_pkg;

    // **************************************************
    // Address layout
    // **************************************************

    localparam int unsigned ADDR_W = 32;

    // 4 KiB page
    localparam int unsigned PAGE_OFFSET_W = 12;

    // 64-byte cache line
    localparam int unsigned LINE_OFFSET_W = 6;

    localparam int unsigned TAG_W = ADDR_W - PAGE_OFFSET_W;

    // **************************************************
    // Burst length
    // **************************************************

    localparam int unsigned COUNT_W = 8;
    localparam int unsigned NBLOCKS_RESET = 8;

    // Signed byte distance, one bit wider than the in-page index
    typedef logic signed [PAGE_OFFSET_W:0] stride_t;

    // Confirmation steps of a table entry
    typedef enum logic [1:0] {
        TS_INIT,
        TS_STRIDE,
        TS_HIT1,
        TS_HIT2
    } train_state_e;

endpackage

// File: hdl/stride_table.sv
`timescale 1ns/1ps

module stride_table #(
    parameter int unsigned TABLE_ENTRIES = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       snoop_valid_i,
    input  logic [pf_pkg::ADDR_W-1:0]  snoop_addr_i,
    input  logic [pf_pkg::COUNT_W-1:0] nblocks_i,
    output logic                       push_o,
    output logic [pf_pkg::ADDR_W-1:0]  desc_base_o,
    output pf_pkg::stride_t            desc_stride_o,
    output logic [pf_pkg::COUNT_W-1:0] desc_nblocks_o
);

    import pf_pkg::*;

    localparam int unsigned IDX_W = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1;

    // One entry per tracked page
    logic                     valid_q  [TABLE_ENTRIES];
    logic [TAG_W-1:0]         tag_q    [TABLE_ENTRIES];
    logic [PAGE_OFFSET_W-1:0] index_q  [TABLE_ENTRIES];
    stride_t                  stride_q [TABLE_ENTRIES];
    train_state_e             state_q  [TABLE_ENTRIES];
    logic [IDX_W-1:0]         age_q    [TABLE_ENTRIES];

    logic [TAG_W-1:0]         snoop_tag;
    logic [PAGE_OFFSET_W-1:0] snoop_index;
    logic                     hit;
    logic [IDX_W-1:0]         hit_idx;
    logic                     free_found;
    logic [IDX_W-1:0]         free_idx;
    logic [IDX_W-1:0]         victim_idx;
    logic [IDX_W-1:0]         sel_idx;
    logic [IDX_W-1:0]         sel_age;
    stride_t                  new_stride;
    logic                     stride_match;
    train_state_e             new_state;
    logic                     emit;
    logic [ADDR_W-1:0]        target_addr;

    assign snoop_tag   = snoop_addr_i[ADDR_W-1:PAGE_OFFSET_W];
    assign snoop_index = snoop_addr_i[PAGE_OFFSET_W-1:0];

    // **************************************************
    // Lookup
    // **************************************************

    // Descending scan so the lowest matching slot wins
    always_comb begin
        hit        = 1'b0;
        hit_idx    = '0;
        free_found = 1'b0;
        free_idx   = '0;
        victim_idx = '0;
        for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
            if (valid_q[i] && (tag_q[i] == snoop_tag)) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
            if (!valid_q[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
            // Ages stay a permutation, the oldest is TABLE_ENTRIES-1
            if (age_q[i] == IDX_W'(TABLE_ENTRIES - 1)) begin
                victim_idx = IDX_W'(i);
            end
        end
    end

    assign sel_idx = hit ? hit_idx : (free_found ? free_idx : victim_idx);
    assign sel_age = age_q[sel_idx];

    assign new_stride   = stride_t'({1'b0, snoop_index}) - stride_t'({1'b0, index_q[hit_idx]});
    assign stride_match = (new_stride == stride_q[hit_idx]) && (new_stride != '0);

    // **************************************************
    // Training sequence
    // **************************************************

    always_comb begin
        new_state = TS_STRIDE;
        emit      = 1'b0;
        if (!hit) begin
            new_state = TS_INIT;
        end else begin
            case (state_q[hit_idx])
                TS_STRIDE: begin
                    if (stride_match) begin
                        new_state = TS_HIT1;
                    end
                end
                TS_HIT1: begin
                    if (stride_match) begin
                        new_state = TS_HIT2;
                    end
                end
                TS_HIT2: begin
                    // Fifth consistent access
                    if (stride_match) begin
                        new_state = TS_INIT;
                        emit      = 1'b1;
                    end
                end
                default: begin
                    new_state = TS_STRIDE;
                end
            endcase
        end
    end

    assign target_addr = snoop_addr_i
                       + {{(ADDR_W - PAGE_OFFSET_W - 1){new_stride[PAGE_OFFSET_W]}}, new_stride};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < TABLE_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
                state_q[i] <= TS_INIT;
                age_q[i]   <= IDX_W'(i);
            end
        end else if (snoop_valid_i) begin
            for (int i = 0; i < TABLE_ENTRIES; i++) begin
                if (sel_idx == IDX_W'(i)) begin
                    valid_q[i] <= 1'b1;
                    state_q[i] <= new_state;
                    age_q[i]   <= '0;
                end else if (age_q[i] < sel_age) begin
                    age_q[i] <= age_q[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (snoop_valid_i) begin
            tag_q[sel_idx]    <= snoop_tag;
            index_q[sel_idx]  <= snoop_index;
            stride_q[sel_idx] <= hit ? new_stride : '0;
        end
    end

    // Descriptor out, one cycle after the snoop
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            push_o <= 1'b0;
        end else begin
            push_o <= snoop_valid_i && emit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (snoop_valid_i && emit) begin
            desc_base_o    <= {target_addr[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
            desc_stride_o  <= new_stride;
            desc_nblocks_o <= nblocks_i;
        end
    end

endmodule

// File: hdl/desc_fifo.sv
`timescale 1ns/1ps

module desc_fifo #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       push_i,
    input  logic [pf_pkg::ADDR_W-1:0]  base_i,
    input  pf_pkg::stride_t            stride_i,
    input  logic [pf_pkg::COUNT_W-1:0] nblocks_i,
    output logic                       valid_o,
    output logic [pf_pkg::ADDR_W-1:0]  base_o,
    output pf_pkg::stride_t            stride_o,
    output logic [pf_pkg::COUNT_W-1:0] nblocks_o,
    input  logic                       pop_i
);

    import pf_pkg::*;

    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [ADDR_W-1:0]  base_mem    [FIFO_DEPTH];
    stride_t            stride_mem  [FIFO_DEPTH];
    logic [COUNT_W-1:0] nblocks_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             rd_adv;

    // Wrap for any depth, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end else begin
            return ptr + 1'b1;
        end
    endfunction

    assign full    = (count_q == CNT_W'(FIFO_DEPTH));
    // Push into a full buffer pushes the oldest entry out
    assign rd_adv  = pop_i || (push_i && full);
    assign valid_o = (count_q != '0);

    assign base_o    = base_mem[rd_ptr_q];
    assign stride_o  = stride_mem[rd_ptr_q];
    assign nblocks_o = nblocks_mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (rd_adv) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push_i && !rd_adv) begin
                count_q <= count_q + 1'b1;
            end else if (rd_adv && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            base_mem[wr_ptr_q]    <= base_i;
            stride_mem[wr_ptr_q]  <= stride_i;
            nblocks_mem[wr_ptr_q] <= nblocks_i;
        end
    end

endmodule

// File: hdl/prefetch_engine.sv
`timescale 1ns/1ps

module prefetch_engine #(
    parameter int unsigned MAX_CREDITS = 2
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       valid_i,
    input  logic [pf_pkg::ADDR_W-1:0]  base_i,
    input  pf_pkg::stride_t            stride_i,
    input  logic [pf_pkg::COUNT_W-1:0] nblocks_i,
    output logic                       pop_o,
    output logic                       req_valid_o,
    output logic [pf_pkg::ADDR_W-1:0]  req_addr_o,
    input  logic                       credit_i
);

    import pf_pkg::*;

    localparam int unsigned CRED_W = $clog2(MAX_CREDITS + 1);

    logic               busy_q;
    logic [COUNT_W-1:0] remain_q;
    logic [CRED_W-1:0]  credits_q;
    logic [ADDR_W-1:0]  addr_q;
    logic [TAG_W-1:0]   tag_q;
    stride_t            stride_q;
    logic               in_page;
    logic               last_req;
    logic [ADDR_W-1:0]  next_addr;

    // **************************************************
    // Request generation
    // **************************************************

    // Burst is confined to the page of its base
    assign in_page = (addr_q[ADDR_W-1:PAGE_OFFSET_W] == tag_q);

    assign pop_o       = !busy_q && valid_i;
    assign req_valid_o = busy_q && in_page && (credits_q != '0);
    assign req_addr_o  = {addr_q[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
    assign last_req    = req_valid_o && (remain_q == COUNT_W'(1));

    assign next_addr = addr_q
                     + {{(ADDR_W - PAGE_OFFSET_W - 1){stride_q[PAGE_OFFSET_W]}}, stride_q};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q   <= 1'b0;
            remain_q <= '0;
        end else if (pop_o) begin
            // An empty burst is dropped right away
            busy_q   <= (nblocks_i != '0);
            remain_q <= nblocks_i;
        end else if (busy_q) begin
            if (!in_page || last_req) begin
                busy_q <= 1'b0;
            end
            if (req_valid_o) begin
                remain_q <= remain_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            addr_q   <= base_i;
            tag_q    <= base_i[ADDR_W-1:PAGE_OFFSET_W];
            stride_q <= stride_i;
        end else if (req_valid_o) begin
            addr_q <= next_addr;
        end
    end

    // **************************************************
    // Credits from the cache
    // **************************************************

    // One spent per request, one back per credit_i pulse
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credits_q <= CRED_W'(MAX_CREDITS);
        end else begin
            credits_q <= credits_q - CRED_W'(req_valid_o) + CRED_W'(credit_i);
        end
    end

endmodule

// File: hdl/stride_prefetcher.sv
`timescale 1ns/1ps

module stride_prefetcher #(
    parameter int unsigned TABLE_ENTRIES = 4,
    parameter int unsigned FIFO_DEPTH    = 4,
    parameter int unsigned MAX_CREDITS   = 2
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       snoop_valid_i,
    input  logic [pf_pkg::ADDR_W-1:0]  snoop_addr_i,
    input  logic                       cfg_valid_i,
    input  logic [pf_pkg::COUNT_W-1:0] cfg_nblocks_i,
    output logic                       req_valid_o,
    output logic [pf_pkg::ADDR_W-1:0]  req_addr_o,
    input  logic                       credit_i
);

    import pf_pkg::*;

    logic [COUNT_W-1:0] nblocks_q;

    logic               push;
    logic [ADDR_W-1:0]  push_base;
    stride_t            push_stride;
    logic [COUNT_W-1:0] push_nblocks;

    logic               head_valid;
    logic [ADDR_W-1:0]  head_base;
    stride_t            head_stride;
    logic [COUNT_W-1:0] head_nblocks;
    logic               pop;

    // Block count written by software
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            nblocks_q <= COUNT_W'(NBLOCKS_RESET);
        end else if (cfg_valid_i) begin
            nblocks_q <= cfg_nblocks_i;
        end
    end

    stride_table #(
        .TABLE_ENTRIES (TABLE_ENTRIES)
    ) u_table (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .snoop_valid_i  (snoop_valid_i),
        .snoop_addr_i   (snoop_addr_i),
        .nblocks_i      (nblocks_q),
        .push_o         (push),
        .desc_base_o    (push_base),
        .desc_stride_o  (push_stride),
        .desc_nblocks_o (push_nblocks)
    );

    desc_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .push_i    (push),
        .base_i    (push_base),
        .stride_i  (push_stride),
        .nblocks_i (push_nblocks),
        .valid_o   (head_valid),
        .base_o    (head_base),
        .stride_o  (head_stride),
        .nblocks_o (head_nblocks),
        .pop_i     (pop)
    );

    prefetch_engine #(
        .MAX_CREDITS (MAX_CREDITS)
    ) u_engine (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .valid_i     (head_valid),
        .base_i      (head_base),
        .stride_i    (head_stride),
        .nblocks_i   (head_nblocks),
        .pop_o       (pop),
        .req_valid_o (req_valid_o),
        .req_addr_o  (req_addr_o),
        .credit_i    (credit_i)
    );

endmodule

// File: testbench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Row fields in order are name, first snoop address, address step, snoop count (0 for idle),
// cfg write, block count, credits on, expected base, expected stride and expected count
task automatic load_vectors();
    // Ascending stride of 128 in one page
    add_row("pos_stride",     32'h00010000,  128, 5, 0, 0, 1, 32'h00010280,  128, 8);

    // Descending stride whose burst stops at the page start
    add_row("neg_clamp",      32'h00020610, -256, 5, 0, 0, 1, 32'h00020100, -256, 2);

    // Broken sequence and repeated zero strides before a clean run
    add_row("broken_seq",     32'h00030000,   64, 4, 0, 0, 1, 32'h00000000,    0, 0);
    add_row("broken_jump",    32'h00030180,    0, 5, 0, 0, 1, 32'h00000000,    0, 0);
    add_row("broken_retrain", 32'h000301c0,   64, 4, 0, 0, 1, 32'h000302c0,   64, 8);

    // Shorter bursts from here on
    add_row("cfg_nblocks",    32'h00000000,    0, 0, 1, 3, 1, 32'h00000000,    0, 0);

    // Two pages trained interleaved
    add_row("interleave_a",   32'h00040000,    0, 1, 0, 0, 1, 32'h00000000,    0, 0);
    add_row("interleave_b",   32'h00050000,    0, 1, 0, 0, 1, 32'h00000000,    0, 0);
    add_row("interleave_a",   32'h00040040,    0, 1, 0, 0, 1, 32'h00000000,    0, 0);
    add_row("interleave_b",   32'h00050080,    0, 1, 0, 0, 1, 32'h00000000,    0, 0);
    add_row("interleave_a",   32'h00040080,    0, 1, 0, 0, 1, 32'h00000000,    0, 0);
    add_row("interleave_b",   32'h00050100,    0, 1, 0, 0, 1, 32'h00000000,    0, 0);
    add_row("interleave_a",   32'h000400c0,    0, 1, 0, 0, 1, 32'h00000000,    0, 0);
    add_row("interleave_b",   32'h00050180,    0, 1, 0, 0, 1, 32'h00000000,    0, 0);
    add_row("interleave_a",   32'h00040100,    0, 1, 0, 0, 1, 32'h00040140,   64, 3);
    add_row("interleave_b",   32'h00050200,    0, 1, 0, 0, 1, 32'h00050280,  128, 3);

    // Four new pages push the half-trained page out
    add_row("lru_train",      32'h00060000,   64, 4, 0, 0, 1, 32'h00000000,    0, 0);
    add_row("lru_evict",      32'h00070000, 'h10000, 4, 0, 0, 1, 32'h00000000, 0, 0);
    add_row("lru_retrain",    32'h00060100,   64, 5, 0, 0, 1, 32'h00060240,   64, 3);

    // Credits held back while the FIFO overflows and loses its oldest descriptor
    add_row("bp_first",       32'h000b0000,   64, 5, 0, 0, 0, 32'h000b0140,   64, 3);
    add_row("bp_drop",        32'h000b0140,   64, 4, 0, 0, 0, 32'h00000000,    0, 0);
    add_row("bp_d3",          32'h000b0240,   64, 4, 0, 0, 0, 32'h000b0340,   64, 3);
    add_row("bp_d4",          32'h000b0340,   64, 4, 0, 0, 0, 32'h000b0440,   64, 3);
    add_row("bp_d5",          32'h000b0440,   64, 4, 0, 0, 0, 32'h000b0540,   64, 3);
    add_row("bp_d6",          32'h000b0540,   64, 4, 0, 0, 0, 32'h000b0640,   64, 3);
    add_row("bp_resume",      32'h00000000,    0, 0, 0, 0, 1, 32'h00000000,    0, 0);
endtask

`endif

// File: testbench/tb_stride_prefetcher.sv
`timescale 1ns/1ps

module tb_stride_prefetcher;

    import pf_pkg::*;

    localparam int unsigned TABLE_ENTRIES = 4;
    localparam int unsigned FIFO_DEPTH    = 4;
    localparam int unsigned MAX_CREDITS   = 2;
    localparam time         CLK_PERIOD    = 100ns;

    logic               clk_i = 1'b0;
    logic               rst_ni;
    logic               snoop_valid_i;
    logic [ADDR_W-1:0]  snoop_addr_i;
    logic               cfg_valid_i;
    logic [COUNT_W-1:0] cfg_nblocks_i;
    logic               req_valid_o;
    logic [ADDR_W-1:0]  req_addr_o;
    logic               credit_i = 1'b0;

    // Stimulus rows
    string              row_name[$];
    logic [ADDR_W-1:0]  row_addr[$];
    int                 row_step[$];
    int                 row_nsnoop[$];
    bit                 row_cfg[$];
    logic [COUNT_W-1:0] row_nblocks[$];
    bit                 row_credit[$];
    logic [ADDR_W-1:0]  row_exp_base[$];
    int                 row_exp_stride[$];
    int                 row_exp_count[$];

    // Requests still to come in issue order
    logic [ADDR_W-1:0]  exp_addr[$];
    string              exp_name[$];

    int                 num_rows = 0;
    int                 outstanding = 0;
    bit                 credits_on = 1'b1;
    int unsigned        seed_ret;
    logic [ADDR_W-1:0]  mon_exp;
    string              mon_name;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    stride_prefetcher #(
        .TABLE_ENTRIES (TABLE_ENTRIES),
        .FIFO_DEPTH    (FIFO_DEPTH),
        .MAX_CREDITS   (MAX_CREDITS)
    ) dut0 (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .snoop_valid_i (snoop_valid_i),
        .snoop_addr_i  (snoop_addr_i),
        .cfg_valid_i   (cfg_valid_i),
        .cfg_nblocks_i (cfg_nblocks_i),
        .req_valid_o   (req_valid_o),
        .req_addr_o    (req_addr_o),
        .credit_i      (credit_i)
    );

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic add_row(input string name, input logic [ADDR_W-1:0] addr, input int step,
                           input int nsnoop, input bit cfg, input logic [COUNT_W-1:0] nblocks,
                           input bit credit, input logic [ADDR_W-1:0] exp_base,
                           input int exp_stride, input int exp_count);
        row_name.push_back(name);
        row_addr.push_back(addr);
        row_step.push_back(step);
        row_nsnoop.push_back(nsnoop);
        row_cfg.push_back(cfg);
        row_nblocks.push_back(nblocks);
        row_credit.push_back(credit);
        row_exp_base.push_back(exp_base);
        row_exp_stride.push_back(exp_stride);
        row_exp_count.push_back(exp_count);
    endtask

    `include "tb_vectors.svh"

    // **************************************************
    // Row application
    // **************************************************

    task automatic apply_row(input int r);
        logic [ADDR_W-1:0] addr;
        addr       = row_addr[r];
        credits_on <= row_credit[r];
        // One expected address per line of the burst
        for (int k = 0; k < row_exp_count[r]; k++) begin
            exp_addr.push_back(row_exp_base[r] + k * row_exp_stride[r]);
            exp_name.push_back(row_name[r]);
        end
        if (row_cfg[r]) begin
            @(negedge clk_i);
            cfg_valid_i   = 1'b1;
            cfg_nblocks_i = row_nblocks[r];
        end
        for (int k = 0; k < row_nsnoop[r]; k++) begin
            @(negedge clk_i);
            cfg_valid_i   = 1'b0;
            snoop_valid_i = 1'b1;
            snoop_addr_i  = addr;
            addr          = addr + row_step[r];
        end
        @(negedge clk_i);
        cfg_valid_i   = 1'b0;
        snoop_valid_i = 1'b0;
        // With credits flowing, let the queued bursts finish
        while (credits_on && (exp_addr.size() != 0 || outstanding != 0)) begin
            @(negedge clk_i);
        end
    endtask

    // Credits come back at random while any are out
    always @(negedge clk_i) begin
        if (credits_on && outstanding > 0 && ($urandom % 3 != 0)) begin
            credit_i = 1'b1;
        end else begin
            credit_i = 1'b0;
        end
    end

    // **************************************************
    // Request monitor
    // **************************************************

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            outstanding <= 0;
        end else begin
            if (req_valid_o) begin
                assert (outstanding < MAX_CREDITS) else begin
                    $display("request to 0x%08h issued with no credit left", req_addr_o);
                    abort_run();
                end
                assert (exp_addr.size() > 0) else begin
                    $display("request to 0x%08h arrived when none was expected", req_addr_o);
                    abort_run();
                end
                mon_exp  = exp_addr.pop_front();
                mon_name = exp_name.pop_front();
                assert (req_addr_o == mon_exp) else begin
                    $display("mismatch %s expected 0x%08h actual 0x%08h",
                             mon_name, mon_exp, req_addr_o);
                    abort_run();
                end
            end
            outstanding <= outstanding + int'(req_valid_o) - int'(credit_i);
        end
    end

    initial begin
        wait (num_rows > 0);
        repeat (num_rows * 40) @(posedge clk_i);
        $display("timeout after %0d clock periods without finishing the rows", num_rows * 40);
        abort_run();
    end

    initial begin
        seed_ret      = $urandom(32'hc5109fbe);
        rst_ni        = 1'b0;
        snoop_valid_i = 1'b0;
        snoop_addr_i  = '0;
        cfg_valid_i   = 1'b0;
        cfg_nblocks_i = '0;
        load_vectors();
        num_rows = row_name.size();
        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        for (int r = 0; r < num_rows; r++) begin
            apply_row(r);
        end
        // Quiet period to catch stray requests
        repeat (20) @(negedge clk_i);
        $display("TEST OK");
        $finish;
    end

endmodule

// File: flist.f
+incdir+testbench
hdl/pf_pkg.sv
hdl/stride_table.sv
hdl/desc_fifo.sv
hdl/prefetch_engine.sv
hdl/stride_prefetcher.sv
testbench/tb_stride_prefetcher.sv

// File: Bender.yml
package:
  name: stride_prefetcher

sources:
  - hdl/pf_pkg.sv
  - hdl/stride_table.sv
  - hdl/desc_fifo.sv
  - hdl/prefetch_engine.sv
  - hdl/stride_prefetcher.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_stride_prefetcher.sv
